//--- matrix_pkg.sv
// Shared geometry, opcodes and index widths for the matrix store
// SLOT_CNT must be a power of two because the slot pointer wraps by overflow
// MAX_DIM bounds both the row count and the column count
// Elements are unsigned bytes and there is no signed arithmetic anywhere
package matrix_pkg;

  // ==============================
  // Storage geometry
  // ==============================
  localparam int MAX_DIM  = 4;
  localparam int SLOT_CNT = 4;

  // Dimension value 1..MAX_DIM
  localparam int DIM_W  = $clog2(MAX_DIM + 1);
  // Row or column index 0..MAX_DIM-1
  localparam int IDX_W  = $clog2(MAX_DIM);
  localparam int SLOT_W = $clog2(SLOT_CNT);
  // Stored count 0..SLOT_CNT
  localparam int CNT_W  = $clog2(SLOT_CNT + 1);

  // ==============================
  // Command opcodes
  // ==============================
  localparam logic [7:0] OP_STORE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;

  // One matrix element, also the serial byte
  typedef logic [7:0] elem_t;

endpackage

//--- matrix_if.sv
// Storage write and read buses between parser, store and sender
// Write commands are single-cycle pulses, wr_new before any element
// Read data is registered and valid one cycle after the address
`timescale 1ns/1ps

// Parser to store
interface mat_wr_if;
  logic                             wr_new;
  logic [matrix_pkg::DIM_W-1:0]     dim_r;
  logic [matrix_pkg::DIM_W-1:0]     dim_c;
  logic                             wr_elem;
  logic [matrix_pkg::IDX_W-1:0]     row;
  logic [matrix_pkg::IDX_W-1:0]     col;
  matrix_pkg::elem_t                data;

  modport master (output wr_new, dim_r, dim_c, wr_elem, row, col, data);
  modport slave  (input  wr_new, dim_r, dim_c, wr_elem, row, col, data);
endinterface

// Sender to store
interface mat_rd_if;
  logic [matrix_pkg::SLOT_W-1:0]    rd_id;
  logic [matrix_pkg::IDX_W-1:0]     row;
  logic [matrix_pkg::IDX_W-1:0]     col;
  matrix_pkg::elem_t                rd_data;
  logic [matrix_pkg::DIM_W-1:0]     rd_dim_r;
  logic [matrix_pkg::DIM_W-1:0]     rd_dim_c;
  // Slot holds a matrix
  logic                             rd_valid;

  modport master (output rd_id, row, col, input rd_data, rd_dim_r, rd_dim_c, rd_valid);
  modport slave  (input rd_id, row, col, output rd_data, rd_dim_r, rd_dim_c, rd_valid);
endinterface

//--- uart_rx.sv
// 8N1 serial receiver, LSB first, no parity
// CLKS_PER_BIT must be at least 4
// A low stop bit drops the byte silently, no error flag
// No back-pressure, rx_data is only meaningful on the rx_valid pulse
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              rxd,
  output matrix_pkg::elem_t rx_data,
  output logic              rx_valid
);

  localparam int TICK_W = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t            state;
  logic [1:0]        sync_q;
  logic [TICK_W-1:0] tick;
  logic [2:0]        bit_idx;
  matrix_pkg::elem_t shift_q;
  logic              tick_done;
  logic              tick_half;
  logic              line;

  // Two-flop synchronizer output
  assign line      = sync_q[1];
  assign tick_done = (tick == TICK_W'(CLKS_PER_BIT - 1));
  assign tick_half = (tick == TICK_W'(CLKS_PER_BIT / 2 - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q   <= 2'b11;
      state    <= S_IDLE;
      tick     <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], rxd};
      rx_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          tick    <= '0;
          bit_idx <= '0;
          // Falling start edge
          if (!line) state <= S_START;
        end
        S_START: begin
          if (tick_half) begin
            tick  <= '0;
            // Glitch shorter than half a bit goes back to idle
            state <= line ? S_IDLE : S_DATA;
          end else begin
            tick <= tick + 1'b1;
          end
        end
        S_DATA: begin
          if (tick_done) begin
            tick    <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= S_STOP;
          end else begin
            tick <= tick + 1'b1;
          end
        end
        default: begin
          // Mid stop bit
          if (tick_done) begin
            state    <= S_IDLE;
            rx_valid <= line;
          end else begin
            tick <= tick + 1'b1;
          end
        end
      endcase
    end
  end

  // Data path, mid-bit sampling, LSB first
  always_ff @(posedge clk) begin
    if (state == S_DATA && tick_done) shift_q <= {line, shift_q[7:1]};
    if (state == S_STOP && tick_done && line) rx_data <= shift_q;
  end

  // Never two bytes on back-to-back cycles
  a_rx_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    rx_valid |=> !rx_valid);

endmodule

//--- uart_tx.sv
// 8N1 serial transmitter with a valid/ready byte input
// One byte in flight, ready is high only while the line is idle
// CLKS_PER_BIT must be at least 2
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic              clk,
  input  logic              reset,
  input  matrix_pkg::elem_t tx_data,
  input  logic              tx_valid,
  output logic              tx_ready,
  output logic              txd
);

  localparam int TICK_W = $clog2(CLKS_PER_BIT);

  logic              busy;
  // Stop, data, start; bit 0 drives the line
  logic [9:0]        frame_q;
  logic [TICK_W-1:0] tick;
  logic [3:0]        bit_idx;

  assign tx_ready = !busy;
  assign txd      = frame_q[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      frame_q <= '1;
      tick    <= '0;
      bit_idx <= '0;
    end else if (!busy) begin
      tick    <= '0;
      bit_idx <= '0;
      // Accept, start bit on the line next cycle
      if (tx_valid) begin
        busy    <= 1'b1;
        frame_q <= {1'b1, tx_data, 1'b0};
      end
    end else if (tick == TICK_W'(CLKS_PER_BIT - 1)) begin
      tick    <= '0;
      // Shift in ones so the line rests high
      frame_q <= {1'b1, frame_q[9:1]};
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      tick <= tick + 1'b1;
    end
  end

  // Idle line is always marking
  a_idle_high: assert property (@(posedge clk) disable iff (reset)
    !busy |-> txd);

endmodule

//--- matrix_input.sv
// Command parser for store and read frames
// Store: opcode, rows, cols, then rows*cols elements in row-major order
// Read: opcode, slot id. Bad opcode, bad dims or bad id pulse err for one cycle
// After an error the next byte is taken as an opcode
// A read is dropped while a request is pending or the sender is busy
`timescale 1ns/1ps

module matrix_input (
  input  logic                          clk,
  input  logic                          reset,
  input  matrix_pkg::elem_t             rx_data,
  input  logic                          rx_valid,
  mat_wr_if.master                      wr,
  output logic [matrix_pkg::SLOT_W-1:0] req_id,
  output logic                          req_valid,
  input  logic                          req_ready,
  output logic                          err,
  input  logic [matrix_pkg::CNT_W-1:0]  matrix_cnt
);

  typedef enum logic [2:0] {S_OP, S_DIM_R, S_DIM_C, S_ELEM, S_ID} state_t;

  state_t                       state;
  matrix_pkg::elem_t            dim_r_q;
  matrix_pkg::elem_t            dim_c_q;
  logic [matrix_pkg::IDX_W-1:0] row_q;
  logic [matrix_pkg::IDX_W-1:0] col_q;
  logic                         last_col;
  logic                         last_row;

  // Legal dimension is 1..MAX_DIM
  function automatic logic dim_ok(matrix_pkg::elem_t d);
    return (d != 8'd0) && (d <= matrix_pkg::elem_t'(matrix_pkg::MAX_DIM));
  endfunction

  assign last_col = (matrix_pkg::elem_t'(col_q) == dim_c_q - 8'd1);
  assign last_row = (matrix_pkg::elem_t'(row_q) == dim_r_q - 8'd1);

  // Dims only matter once validated
  assign wr.dim_r = dim_r_q[matrix_pkg::DIM_W-1:0];
  assign wr.dim_c = dim_c_q[matrix_pkg::DIM_W-1:0];
  assign wr.row   = row_q;
  assign wr.col   = col_q;

  // ==============================
  // Frame FSM
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= S_OP;
      wr.wr_new  <= 1'b0;
      wr.wr_elem <= 1'b0;
      req_valid  <= 1'b0;
      err        <= 1'b0;
      row_q      <= '0;
      col_q      <= '0;
    end else begin
      wr.wr_new  <= 1'b0;
      wr.wr_elem <= 1'b0;
      err        <= 1'b0;
      if (req_valid && req_ready) req_valid <= 1'b0;
      // Index steps after the element write has been on the bus
      if (wr.wr_new) begin
        row_q <= '0;
        col_q <= '0;
      end else if (wr.wr_elem) begin
        if (last_col) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
      if (rx_valid) begin
        case (state)
          S_OP: begin
            case (rx_data)
              matrix_pkg::OP_STORE: state <= S_DIM_R;
              matrix_pkg::OP_READ:  state <= S_ID;
              default:              err   <= 1'b1;
            endcase
          end
          S_DIM_R: state <= S_DIM_C;
          S_DIM_C: begin
            // Both dims checked here, a bad frame writes nothing
            if (dim_ok(dim_r_q) && dim_ok(rx_data)) begin
              wr.wr_new <= 1'b1;
              state     <= S_ELEM;
            end else begin
              err   <= 1'b1;
              state <= S_OP;
            end
          end
          S_ELEM: begin
            wr.wr_elem <= 1'b1;
            if (last_col && last_row) state <= S_OP;
          end
          default: begin
            state <= S_OP;
            // Empty slot, or sender still occupied
            if (rx_data >= matrix_pkg::elem_t'(matrix_cnt) || req_valid || !req_ready) begin
              err <= 1'b1;
            end else begin
              req_valid <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  // Byte captures
  always_ff @(posedge clk) begin
    if (rx_valid && state == S_DIM_R) dim_r_q <= rx_data;
    if (rx_valid && state == S_DIM_C) dim_c_q <= rx_data;
    if (rx_valid && state == S_ELEM) wr.data <= rx_data;
    // Held while a request waits
    if (rx_valid && state == S_ID && !req_valid) req_id <= rx_data[matrix_pkg::SLOT_W-1:0];
  end

  a_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(wr.wr_new && wr.wr_elem));

endmodule

//--- matrix_store.sv
// Slot-organized matrix memory with round-robin allocation
// The fifth store overwrites slot 0, matrix_cnt saturates at SLOT_CNT
// Read port is registered, one cycle from address to data
// Element contents are undefined until written
`timescale 1ns/1ps

module matrix_store (
  input  logic                         clk,
  input  logic                         reset,
  mat_wr_if.slave                      wr,
  mat_rd_if.slave                      rd,
  output logic [matrix_pkg::CNT_W-1:0] matrix_cnt
);

  localparam int DW = matrix_pkg::DIM_W;
  localparam int CW = matrix_pkg::CNT_W;

  matrix_pkg::elem_t mem [matrix_pkg::SLOT_CNT][matrix_pkg::MAX_DIM][matrix_pkg::MAX_DIM];
  logic [DW-1:0]     dim_r_mem [matrix_pkg::SLOT_CNT];
  logic [DW-1:0]     dim_c_mem [matrix_pkg::SLOT_CNT];
  // One bit per slot that holds a matrix
  logic [matrix_pkg::SLOT_CNT-1:0] used_q;
  logic [matrix_pkg::SLOT_W-1:0]   wr_ptr;
  // Slot that element writes go to
  logic [matrix_pkg::SLOT_W-1:0]   cur_slot;

  // Allocation and count
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      cur_slot    <= '0;
      used_q      <= '0;
      matrix_cnt  <= '0;
      rd.rd_valid <= 1'b0;
    end else begin
      if (wr.wr_new) begin
        cur_slot       <= wr_ptr;
        // Wraps by overflow
        wr_ptr         <= wr_ptr + 1'b1;
        used_q[wr_ptr] <= 1'b1;
        if (matrix_cnt != CW'(matrix_pkg::SLOT_CNT)) matrix_cnt <= matrix_cnt + 1'b1;
      end
      rd.rd_valid <= used_q[rd.rd_id];
    end
  end

  // Array writes and registered read
  always_ff @(posedge clk) begin
    if (wr.wr_new) begin
      dim_r_mem[wr_ptr] <= wr.dim_r;
      dim_c_mem[wr_ptr] <= wr.dim_c;
    end
    if (wr.wr_elem) mem[cur_slot][wr.row][wr.col] <= wr.data;
    rd.rd_data  <= mem[rd.rd_id][rd.row][rd.col];
    rd.rd_dim_r <= dim_r_mem[rd.rd_id];
    rd.rd_dim_c <= dim_c_mem[rd.rd_id];
  end

  // Parser index must stay inside the dims latched on wr_new
  a_wr_in_bounds: assert property (@(posedge clk) disable iff (reset)
    wr.wr_elem |-> (DW'(wr.row) < dim_r_mem[cur_slot]) && (DW'(wr.col) < dim_c_mem[cur_slot]));

endmodule

//--- matrix_sender.sv
// Streams one stored matrix to the transmitter
// Reply is row count, column count, then elements in row-major order
// One request at a time, req_ready is high only while idle
// Each element waits one cycle of read latency before tx_valid
`timescale 1ns/1ps

module matrix_sender (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [matrix_pkg::SLOT_W-1:0] req_id,
  input  logic                          req_valid,
  output logic                          req_ready,
  mat_rd_if.master                      rd,
  output matrix_pkg::elem_t             tx_data,
  output logic                          tx_valid,
  input  logic                          tx_ready
);

  localparam int DW = matrix_pkg::DIM_W;

  typedef enum logic [2:0] {S_IDLE, S_START, S_DIM_R, S_DIM_C, S_WAIT, S_ELEM} state_t;

  state_t                        state;
  logic [matrix_pkg::SLOT_W-1:0] id_q;
  logic [matrix_pkg::IDX_W-1:0]  row_q;
  logic [matrix_pkg::IDX_W-1:0]  col_q;
  logic                          tx_fire;
  logic                          last_col;
  logic                          last_row;

  assign req_ready = (state == S_IDLE);
  assign rd.rd_id  = id_q;
  assign rd.row    = row_q;
  assign rd.col    = col_q;

  // Dims stay valid for the whole walk since rd_id is held
  assign last_col = (DW'(col_q) == rd.rd_dim_c - 1'b1);
  assign last_row = (DW'(row_q) == rd.rd_dim_r - 1'b1);

  // ==============================
  // Byte source
  // ==============================
  assign tx_valid = (state == S_DIM_R && rd.rd_valid) || state == S_DIM_C || state == S_ELEM;
  assign tx_fire  = tx_valid && tx_ready;

  always_comb begin
    case (state)
      S_DIM_R: tx_data = matrix_pkg::elem_t'(rd.rd_dim_r);
      S_DIM_C: tx_data = matrix_pkg::elem_t'(rd.rd_dim_c);
      default: tx_data = rd.rd_data;
    endcase
  end

  // ==============================
  // Walk FSM
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      id_q  <= '0;
      row_q <= '0;
      col_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req_valid) begin
            id_q  <= req_id;
            row_q <= '0;
            col_q <= '0;
            state <= S_START;
          end
        end
        // Read latency for the new slot
        S_START: state <= S_DIM_R;
        S_DIM_R: begin
          // Empty slot, nothing to send
          if (!rd.rd_valid) state <= S_IDLE;
          else if (tx_fire) state <= S_DIM_C;
        end
        // Element 0,0 already addressed
        S_DIM_C: if (tx_fire) state <= S_ELEM;
        S_WAIT:  state <= S_ELEM;
        S_ELEM: begin
          if (tx_fire) begin
            if (last_col) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
              state <= last_row ? S_IDLE : S_WAIT;
            end else begin
              col_q <= col_q + 1'b1;
              state <= S_WAIT;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Stalled byte holds until the transmitter takes it
  a_tx_hold: assert property (@(posedge clk) disable iff (reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

//--- matrix_core.sv
// Logical top of the UART matrix store
// CLKS_PER_BIT sets the baud rate for both serial directions
// err is a one-cycle pulse per rejected command
`timescale 1ns/1ps

module matrix_core #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         uart_rx,
  output logic                         uart_tx,
  output logic                         err,
  output logic [matrix_pkg::CNT_W-1:0] matrix_cnt
);

  // ==============================
  // Internal nets
  // ==============================
  matrix_pkg::elem_t             rx_data;
  logic                          rx_valid;
  matrix_pkg::elem_t             tx_data;
  logic                          tx_valid;
  logic                          tx_ready;
  logic [matrix_pkg::SLOT_W-1:0] req_id;
  logic                          req_valid;
  logic                          req_ready;

  // Storage buses
  mat_wr_if wr_bus ();
  mat_rd_if rd_bus ();

  // ==============================
  // Serial line
  // ==============================
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .clk(clk), .reset(reset),
    .rxd(uart_rx),
    .rx_data(rx_data), .rx_valid(rx_valid)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .clk(clk), .reset(reset),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .txd(uart_tx)
  );

  // ==============================
  // Parser, storage, reply
  // ==============================
  matrix_input u_input (
    .clk(clk), .reset(reset),
    .rx_data(rx_data), .rx_valid(rx_valid),
    .wr(wr_bus.master),
    .req_id(req_id), .req_valid(req_valid), .req_ready(req_ready),
    .err(err), .matrix_cnt(matrix_cnt)
  );

  matrix_store u_store (
    .clk(clk), .reset(reset),
    .wr(wr_bus.slave), .rd(rd_bus.slave),
    .matrix_cnt(matrix_cnt)
  );

  matrix_sender u_sender (
    .clk(clk), .reset(reset),
    .req_id(req_id), .req_valid(req_valid), .req_ready(req_ready),
    .rd(rd_bus.master),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
  );

endmodule

//--- tb_matrix_core.sv
// Self-checking testbench for the UART matrix store
// Frames go in at CLKS_PER_BIT = 8
// Replies are sampled at mid-bit on the falling clock edge
// Element values come from $urandom with a fixed seed
`timescale 1ns/1ps

module tb_matrix_core;

  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_NS       = 100;
  localparam int BYTE_CYC     = 10 * CLKS_PER_BIT;
  // Idle wait for rows without a reply
  localparam int QUIET_CYC    = 2 * BYTE_CYC;
  localparam int N_ROWS       = 13;

  // One command frame and what it leaves behind
  typedef struct packed {
    logic       rst;
    logic [7:0] op;
    logic [7:0] a;
    logic [7:0] b;
    logic       exp_err;
    logic [3:0] exp_cnt;
  } row_t;

  // ==============================
  // Stimulus table
  // ==============================
  // rst, opcode, rows or slot id, cols, expect err, count afterwards
  row_t tbl [N_ROWS] = '{
    '{1'b0, matrix_pkg::OP_STORE, 8'd2, 8'd3, 1'b0, 4'd1},
    '{1'b0, matrix_pkg::OP_READ,  8'd0, 8'd0, 1'b0, 4'd1},
    '{1'b0, matrix_pkg::OP_STORE, 8'd1, 8'd1, 1'b0, 4'd2},
    '{1'b0, matrix_pkg::OP_STORE, 8'd4, 8'd4, 1'b0, 4'd3},
    '{1'b0, matrix_pkg::OP_STORE, 8'd3, 8'd2, 1'b0, 4'd4},
    '{1'b0, matrix_pkg::OP_READ,  8'd1, 8'd0, 1'b0, 4'd4},
    // Fifth store wraps onto slot 0
    '{1'b0, matrix_pkg::OP_STORE, 8'd2, 8'd2, 1'b0, 4'd4},
    '{1'b0, matrix_pkg::OP_READ,  8'd0, 8'd0, 1'b0, 4'd4},
    // Rejected frames
    '{1'b0, matrix_pkg::OP_STORE, 8'd0, 8'd2, 1'b1, 4'd4},
    '{1'b0, matrix_pkg::OP_STORE, 8'd2, 8'd5, 1'b1, 4'd4},
    '{1'b0, 8'h07,                8'd0, 8'd0, 1'b1, 4'd4},
    '{1'b0, matrix_pkg::OP_READ,  8'd2, 8'd0, 1'b0, 4'd4},
    // Empty store after a fresh reset
    '{1'b1, matrix_pkg::OP_READ,  8'd0, 8'd0, 1'b1, 4'd0}
  };

  logic                         clk;
  logic                         reset;
  logic                         uart_rx;
  logic                         uart_tx;
  logic                         err;
  logic [matrix_pkg::CNT_W-1:0] matrix_cnt;

  // Reference model with row-major elements per slot
  logic [7:0]  model_mem [matrix_pkg::SLOT_CNT][matrix_pkg::MAX_DIM * matrix_pkg::MAX_DIM];
  int          model_r [matrix_pkg::SLOT_CNT];
  int          model_c [matrix_pkg::SLOT_CNT];
  int          model_ptr;

  logic [7:0]  rx_q [$];
  logic [7:0]  exp_q [$];
  int          err_seen;
  int unsigned seed_val;
  longint      limit_ns;

  matrix_core #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (
    .clk(clk), .reset(reset),
    .uart_rx(uart_rx), .uart_tx(uart_tx),
    .err(err), .matrix_cnt(matrix_cnt)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  // ==============================
  // Reporting and drivers
  // ==============================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_val(input string name, input int exp, input int act);
    assert (exp == act) else
      fail_run($sformatf("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act));
  endtask

  // Reset for 3 cycles and clear the model and capture
  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    model_ptr = 0;
    rx_q.delete();
    err_seen = 0;
  endtask

  // 8N1 frame sent LSB first
  task automatic send_byte(input logic [7:0] val);
    logic [9:0] frame;
    int         i;
    int         k;
    frame = {1'b1, val, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      for (k = 1; k < CLKS_PER_BIT; k++) @(posedge clk);
    end
  endtask

  // Sends one row and predicts and checks the reply
  task automatic run_row(input row_t row, input int idx);
    logic [7:0] e;
    int         n;
    int         k;
    int         slot;
    if (row.rst) apply_reset();
    exp_q.delete();
    send_byte(row.op);
    if (row.op == matrix_pkg::OP_STORE) begin
      send_byte(row.a);
      send_byte(row.b);
      if (!row.exp_err) begin
        n = int'(row.a) * int'(row.b);
        model_r[model_ptr] = int'(row.a);
        model_c[model_ptr] = int'(row.b);
        for (k = 0; k < n; k++) begin
          e = 8'($urandom());
          model_mem[model_ptr][k] = e;
          send_byte(e);
        end
        // Round robin over the slots
        model_ptr = (model_ptr + 1) % matrix_pkg::SLOT_CNT;
      end
    end else if (row.op == matrix_pkg::OP_READ) begin
      send_byte(row.a);
      if (!row.exp_err) begin
        slot = int'(row.a);
        exp_q.push_back(8'(model_r[slot]));
        exp_q.push_back(8'(model_c[slot]));
        for (k = 0; k < model_r[slot] * model_c[slot]; k++) exp_q.push_back(model_mem[slot][k]);
      end
    end
    // Wait for the reply and then guard against stray bytes
    if (exp_q.size() > 0) begin
      while (rx_q.size() < exp_q.size()) @(negedge clk);
      repeat (BYTE_CYC + CLKS_PER_BIT) @(posedge clk);
    end else begin
      repeat (QUIET_CYC) @(posedge clk);
    end
    @(negedge clk);
    check_val($sformatf("err, row %0d", idx), int'(row.exp_err), int'(err_seen > 0));
    check_val($sformatf("matrix_cnt, row %0d", idx), int'(row.exp_cnt), int'(matrix_cnt));
    check_val($sformatf("uart_tx reply length, row %0d", idx), exp_q.size(), rx_q.size());
    for (k = 0; k < exp_q.size(); k++) begin
      check_val($sformatf("uart_tx byte %0d, row %0d", k, idx), int'(exp_q[k]), int'(rx_q[k]));
    end
    rx_q.delete();
    err_seen = 0;
  endtask

  // Frame plus reply bytes of the whole table with dims tracked per slot
  function automatic longint watchdog_ns();
    int bytes;
    int r [matrix_pkg::SLOT_CNT];
    int c [matrix_pkg::SLOT_CNT];
    int ptr;
    int slot;
    int i;
    bytes = 0;
    ptr = 0;
    for (i = 0; i < N_ROWS; i++) begin
      if (tbl[i].rst) ptr = 0;
      if (tbl[i].op == matrix_pkg::OP_STORE) begin
        bytes = bytes + 3;
        if (!tbl[i].exp_err) begin
          bytes = bytes + int'(tbl[i].a) * int'(tbl[i].b);
          r[ptr] = int'(tbl[i].a);
          c[ptr] = int'(tbl[i].b);
          ptr = (ptr + 1) % matrix_pkg::SLOT_CNT;
        end
      end else if (tbl[i].op == matrix_pkg::OP_READ) begin
        bytes = bytes + 2;
        slot = int'(tbl[i].a);
        if (!tbl[i].exp_err) bytes = bytes + 2 + r[slot] * c[slot];
      end else begin
        bytes = bytes + 1;
      end
    end
    return longint'(bytes) * 10 * CLKS_PER_BIT * CLK_NS * 2;
  endfunction

  // ==============================
  // Monitors and watchdog
  // ==============================
  // Mid-bit sampling on the falling clock edge
  initial begin : reply_monitor
    logic [7:0] val;
    int         j;
    forever begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        for (j = 0; j < 8; j++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          val[j] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (uart_tx === 1'b1) else fail_run("A reply byte arrived with a low stop bit");
        rx_q.push_back(val);
      end
    end
  end

  // err is a one-cycle pulse
  always @(negedge clk) begin
    if (err === 1'b1) err_seen = err_seen + 1;
  end

  initial begin : watchdog
    limit_ns = watchdog_ns();
    #(limit_ns);
    fail_run("Timeout: the test did not finish within its time limit");
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin : main_seq
    int i;
    seed_val  = $urandom(73199);
    reset     = 1'b1;
    uart_rx   = 1'b1;
    err_seen  = 0;
    model_ptr = 0;
    apply_reset();
    // Quiet line after reset
    repeat (QUIET_CYC) @(posedge clk);
    @(negedge clk);
    check_val("uart_tx after reset", 1, int'(uart_tx));
    check_val("err after reset", 0, err_seen);
    check_val("matrix_cnt after reset", 0, int'(matrix_cnt));
    check_val("uart_tx bytes after reset", 0, rx_q.size());
    for (i = 0; i < N_ROWS; i++) run_row(tbl[i], i);
    $display("All tests passed");
    $finish;
  end

endmodule

//--- build.f
matrix_pkg.sv
matrix_if.sv
uart_rx.sv
uart_tx.sv
matrix_input.sv
matrix_store.sv
matrix_sender.sv
matrix_core.sv
tb_matrix_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the matrix store testbench with Verilator
# The exit status is the simulator's, nonzero on any failure
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module tb_matrix_core \
  -f build.f \
  -o tb_matrix_core
./obj_dir/tb_matrix_core
